//--- logic/fetch_defines.svh
////////////////////
// Fetch defines
// Widths, memory depth, predictor size and reset PC
////////////////////
`ifndef FETCH_DEFINES_SVH
`define FETCH_DEFINES_SVH

// Datapath widths
`define FETCH_ADDR_W 16                    // PC and byte address
`define FETCH_INST_W 16                    // Instruction word

// Instruction memory, word index is PC[5:1]
`define IMEM_ADDR_W  5
`define IMEM_DEPTH   (1 << `IMEM_ADDR_W)   // 32 words

// Predictor tables, index is PC[3:0]
`define PRED_IDX_W   4
`define PRED_DEPTH   (1 << `PRED_IDX_W)    // 16 entries

`define PC_RESET     16'h0000              // First fetch address

`endif

//--- logic/fetch_types_pkg.sv
////////////////////
// Fetch types
// Vector types for addresses, instructions and memory indices
////////////////////
`include "fetch_defines.svh"

package fetch_types_pkg;

  // Byte address, also the PC
  typedef logic [`FETCH_ADDR_W-1:0] addr_t;

  // One instruction word
  typedef logic [`FETCH_INST_W-1:0] inst_t;

  // Word index into the instruction memory
  typedef logic [`IMEM_ADDR_W-1:0] mem_idx_t;

endpackage

//--- logic/predict_pkg.sv
////////////////////
// Predictor types
// Counter states, table index and buffered target
////////////////////
`include "fetch_defines.svh"

package predict_pkg;

  import fetch_types_pkg::*;

  // Index into history table and target buffer
  typedef logic [`PRED_IDX_W-1:0] pred_idx_t;

  // 2-bit saturating counter
  // Top bit set means predict taken
  typedef enum logic [1:0] {
    strong_not_taken = 2'd0,
    weak_not_taken   = 2'd1,
    weak_taken       = 2'd2,
    strong_taken     = 2'd3
  } pred_t;

  // Target held in the buffer, a full byte address
  typedef addr_t target_t;

endpackage

//--- logic/branch_predictor.sv
////////////////////
// Branch predictor
// History counters and target buffer, read at fetch,
// trained by decode
////////////////////
`include "fetch_defines.svh"

module branch_predictor
  import fetch_types_pkg::*;
  import predict_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      enable,          // Fetch enable, gates the read
  input  pred_idx_t pc_idx,          // Fetch PC[3:0]
  input  pred_idx_t id_pc_idx,       // Index of the branch in decode
  input  pred_t     id_prediction,   // Prediction that branch was fetched with
  input  logic      wen_bht,         // Counter update strobe
  input  logic      wen_btb,         // Target write strobe
  input  logic      actual_taken,    // Resolved direction
  input  addr_t     actual_target,   // Resolved target
  output pred_t     prediction,
  output target_t   predicted_target
);

  pred_t   bht [`PRED_DEPTH];        // History table
  target_t btb [`PRED_DEPTH];        // Target buffer
  pred_t   bht_next;                 // Trained counter value

  ////////////////////
  // Counter training
  ////////////////////
  // Step one state toward the resolved direction, saturate at both ends
  always_comb begin
    bht_next = id_prediction;
    case (id_prediction)
      strong_not_taken: bht_next = actual_taken ? weak_not_taken : strong_not_taken;
      weak_not_taken:   bht_next = actual_taken ? weak_taken     : strong_not_taken;
      weak_taken:       bht_next = actual_taken ? strong_taken   : weak_not_taken;
      strong_taken:     bht_next = actual_taken ? strong_taken   : weak_taken;
      default:          bht_next = strong_not_taken;
    endcase
  end

  // Table writes, new value readable the cycle after the strobe
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `PRED_DEPTH; i++) begin
        bht[i] <= strong_not_taken;
        btb[i] <= '0;
      end
    end else begin
      if (wen_bht)
        bht[id_pc_idx] <= bht_next;
      if (wen_btb)
        btb[id_pc_idx] <= actual_target;
    end
  end

  ////////////////////
  // Fetch-side read
  ////////////////////
  // Stalled or blocked fetch sees not-taken and a zero target
  assign prediction       = enable ? bht[pc_idx] : strong_not_taken;
  assign predicted_target = enable ? btb[pc_idx] : '0;

endmodule

//--- logic/fetch_stage.sv
////////////////////
// Fetch stage
// PC register, next-PC choice and instruction gating
////////////////////
`include "fetch_defines.svh"

module fetch_stage
  import fetch_types_pkg::*;
  import predict_pkg::*;
(
  input  logic    clk,
  input  logic    rst,
  input  logic    stall,             // Hold from hazard logic
  input  logic    fetch_grant,       // Memory port free for fetch
  input  logic    update_pc,         // Redirect from decode
  input  addr_t   actual_target,     // Redirect address
  input  pred_t   prediction,        // Counter state at current PC
  input  target_t predicted_target,  // Buffered target at current PC
  input  inst_t   mem_rdata,         // Word at current PC
  output logic    fetch_en,
  output addr_t   pc_curr,
  output addr_t   pc_next,           // Sequential address
  output inst_t   pc_inst
);

  addr_t pc_new;                     // Value loaded at the next enabled edge

  // Fetch only when not stalled and the memory is ours
  assign fetch_en = ~stall & fetch_grant;

  assign pc_next = pc_curr + addr_t'(2);   // 16-bit instructions

  ////////////////////
  // Next PC
  ////////////////////
  // Decode correction first, then a taken prediction, else fall through
  always_comb begin
    if (update_pc)
      pc_new = actual_target;
    else if (prediction[1])            // Weak or strong taken
      pc_new = predicted_target;
    else
      pc_new = pc_next;
  end

  // PC register, holds while fetch is off
  always_ff @(posedge clk) begin
    if (rst)
      pc_curr <= `PC_RESET;
    else if (fetch_en)
      pc_curr <= pc_new;
  end

  // No valid instruction leaves the stage while held
  assign pc_inst = fetch_en ? mem_rdata : '0;

endmodule

//--- logic/imem_arbiter.sv
////////////////////
// Instruction memory arbiter
// Buffers program loads and shares the memory port with fetch
////////////////////
`include "fetch_defines.svh"

module imem_arbiter
  import fetch_types_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     load_en,          // One strobe per word
  input  addr_t    load_addr,        // Byte address of the word
  input  inst_t    load_data,
  input  addr_t    fetch_addr,       // Current PC
  output logic     mem_we,
  output mem_idx_t mem_addr,
  output inst_t    mem_wdata,
  output logic     fetch_grant
);

  logic     buf_valid;               // A write is pending
  mem_idx_t buf_idx;                 // Word index of pending write
  inst_t    buf_data;

  // One-entry write buffer
  // A new strobe refills it in the same edge the old word is written
  always_ff @(posedge clk) begin
    if (rst)
      buf_valid <= 1'b0;
    else
      buf_valid <= load_en;
  end

  always_ff @(posedge clk) begin
    if (load_en) begin
      buf_idx  <= load_addr[`IMEM_ADDR_W:1];   // Drop byte bit
      buf_data <= load_data;
    end
  end

  ////////////////////
  // Port grant
  ////////////////////
  // Pending write owns the port, fetch waits
  assign mem_we      = buf_valid;
  assign mem_addr    = buf_valid ? buf_idx : fetch_addr[`IMEM_ADDR_W:1];
  assign mem_wdata   = buf_data;
  assign fetch_grant = ~buf_valid;

endmodule

//--- logic/instr_mem.sv
////////////////////
// Instruction memory
// 32 words, one shared port
////////////////////
`include "fetch_defines.svh"

module instr_mem
  import fetch_types_pkg::*;
(
  input  logic     clk,
  input  logic     we,               // Write strobe from arbiter
  input  mem_idx_t addr,             // Word index
  input  inst_t    wdata,
  output inst_t    rdata             // Word at addr, same cycle
);

  inst_t mem [`IMEM_DEPTH];          // Program storage, loaded through the port

  // Write at the edge, visible next cycle
  always_ff @(posedge clk) begin
    if (we)
      mem[addr] <= wdata;
  end

  // Combinational read
  assign rdata = mem[addr];

endmodule

//--- logic/fetch_top.sv
////////////////////
// Fetch top
// Fetch stage, predictor, load arbiter and instruction memory
////////////////////
`include "fetch_defines.svh"

module fetch_top
  import fetch_types_pkg::*;
  import predict_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      stall,           // Level from hazard logic
  input  addr_t     actual_target,   // Decode resolution
  input  logic      actual_taken,
  input  logic      wen_btb,
  input  logic      wen_bht,
  input  logic      update_pc,
  input  pred_idx_t id_pc_idx,
  input  pred_t     id_prediction,
  input  logic      load_en,         // Program load port
  input  addr_t     load_addr,
  input  inst_t     load_data,
  output addr_t     pc_curr,
  output addr_t     pc_next,
  output inst_t     pc_inst,
  output pred_t     prediction,
  output target_t   predicted_target
);

  logic     fetch_en;
  logic     fetch_grant;
  logic     mem_we;
  mem_idx_t mem_addr;
  inst_t    mem_wdata;
  inst_t    mem_rdata;

  ////////////////////
  // Fetch side
  ////////////////////
  fetch_stage fetch_stage_i (
    .clk              (clk),
    .rst              (rst),
    .stall            (stall),
    .fetch_grant      (fetch_grant),
    .update_pc        (update_pc),
    .actual_target    (actual_target),
    .prediction       (prediction),
    .predicted_target (predicted_target),
    .mem_rdata        (mem_rdata),
    .fetch_en         (fetch_en),
    .pc_curr          (pc_curr),
    .pc_next          (pc_next),
    .pc_inst          (pc_inst)
  );

  branch_predictor branch_predictor_i (
    .clk              (clk),
    .rst              (rst),
    .enable           (fetch_en),
    .pc_idx           (pc_curr[`PRED_IDX_W-1:0]),   // Low PC bits
    .id_pc_idx        (id_pc_idx),
    .id_prediction    (id_prediction),
    .wen_bht          (wen_bht),
    .wen_btb          (wen_btb),
    .actual_taken     (actual_taken),
    .actual_target    (actual_target),
    .prediction       (prediction),
    .predicted_target (predicted_target)
  );

  ////////////////////
  // Memory side
  ////////////////////
  imem_arbiter imem_arbiter_i (
    .clk         (clk),
    .rst         (rst),
    .load_en     (load_en),
    .load_addr   (load_addr),
    .load_data   (load_data),
    .fetch_addr  (pc_curr),
    .mem_we      (mem_we),
    .mem_addr    (mem_addr),
    .mem_wdata   (mem_wdata),
    .fetch_grant (fetch_grant)
  );

  instr_mem instr_mem_i (
    .clk   (clk),
    .we    (mem_we),
    .addr  (mem_addr),
    .wdata (mem_wdata),
    .rdata (mem_rdata)
  );

endmodule

//--- test/fetch_tb.sv
////////////////////
// Fetch testbench
// Loads a random program, then runs stalls, load collisions, redirects
// and predictor training against a cycle model of the fetch block
////////////////////
`include "fetch_defines.svh"

module fetch_tb
  import fetch_types_pkg::*;
  import predict_pkg::*;
();

  logic      clk;
  logic      rst;
  logic      stall;
  addr_t     actual_target;
  logic      actual_taken;
  logic      wen_btb;
  logic      wen_bht;
  logic      update_pc;
  pred_idx_t id_pc_idx;
  pred_t     id_prediction;
  logic      load_en;
  addr_t     load_addr;
  inst_t     load_data;
  addr_t     pc_curr;
  addr_t     pc_next;
  inst_t     pc_inst;
  pred_t     prediction;
  target_t   predicted_target;

  // Reference state, stepped at every rising edge
  addr_t                  m_pc;
  logic                   m_buf_valid;
  mem_idx_t               m_buf_idx;
  inst_t                  m_buf_data;
  inst_t                  m_mem [`IMEM_DEPTH];
  logic [`IMEM_DEPTH-1:0] m_loaded = '0;     // Words written so far
  pred_t                  m_bht [`PRED_DEPTH];
  target_t                m_btb [`PRED_DEPTH];
  logic                   model_ready = 1'b0;
  logic [31:0]            lfsr_state = 32'h848af251;
  int                     error_count = 0;

  fetch_top dut_i (.*);

  initial clk = 1'b0;
  always #10 clk = ~clk;              // Period 20

  ////////////////////
  // Reference rules
  ////////////////////
  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_state[0]};
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h80200003) : (lfsr_state >> 1);
    end
    return v;
  endfunction

  function automatic addr_t random_even_addr();
    return addr_t'({random_bits(15), 1'b0});
  endfunction

  // One step toward the resolved direction, held at both ends
  function automatic pred_t ref_counter_step(input pred_t s, input logic taken);
    if (taken)
      return (s == strong_taken) ? strong_taken : pred_t'(s + 2'd1);
    return (s == strong_not_taken) ? strong_not_taken : pred_t'(s - 2'd1);
  endfunction

  // Redirect beats prediction, prediction beats PC+2
  function automatic addr_t ref_next_pc(input addr_t pc, input logic redirect,
                                        input addr_t target, input pred_t p,
                                        input target_t ptarget);
    if (redirect)
      return target;
    if (p >= weak_taken)                // Upper half predicts taken
      return ptarget;
    return pc + addr_t'(2);
  endfunction

  always @(posedge clk) begin : model_update
    logic en;
    en = ~stall & ~m_buf_valid;       // Pending write blocks fetch
    if (m_buf_valid) begin
      m_mem[m_buf_idx]    = m_buf_data;
      m_loaded[m_buf_idx] = 1'b1;
    end
    if (load_en) begin
      m_buf_idx  = load_addr[`IMEM_ADDR_W:1];
      m_buf_data = load_data;
    end
    if (rst) begin
      m_buf_valid = 1'b0;
      m_pc        = `PC_RESET;
      for (int i = 0; i < `PRED_DEPTH; i++) begin
        m_bht[i] = strong_not_taken;
        m_btb[i] = '0;
      end
    end else begin
      m_buf_valid = load_en;
      if (en)
        m_pc = ref_next_pc(m_pc, update_pc, actual_target,
                           m_bht[m_pc[`PRED_IDX_W-1:0]], m_btb[m_pc[`PRED_IDX_W-1:0]]);
      if (wen_bht)
        m_bht[id_pc_idx] = ref_counter_step(id_prediction, actual_taken);
      if (wen_btb)
        m_btb[id_pc_idx] = actual_target;
    end
    model_ready = 1'b1;
  end

  ////////////////////
  // Checks
  ////////////////////
  task automatic report_failure(input string what);
    error_count++;
    $display("%s", what);
    $display("Simulation failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_addr(input string name, input addr_t exp, input addr_t act);
    if (act !== exp)
      report_failure($sformatf("Fail at %0t: %s expected %h, got %h", $time, name, exp, act));
  endtask

  task automatic check_inst(input string name, input inst_t exp, input inst_t act);
    if (act !== exp)
      report_failure($sformatf("Fail at %0t: %s expected %h, got %h", $time, name, exp, act));
  endtask

  task automatic check_pred(input string name, input pred_t exp, input pred_t act);
    if (act !== exp)
      report_failure($sformatf("Fail at %0t: %s expected %0d, got %0d", $time, name, exp, act));
  endtask

  // Outputs settled since the rising edge, inputs change only by NBA
  always @(negedge clk) begin : compare_outputs
    logic      en;
    pred_idx_t pi;
    mem_idx_t  mi;
    if (model_ready) begin
      en = ~stall & ~m_buf_valid;
      pi = m_pc[`PRED_IDX_W-1:0];
      mi = m_pc[`IMEM_ADDR_W:1];
      check_addr("pc_curr", m_pc, pc_curr);
      check_addr("pc_next", m_pc + addr_t'(2), pc_next);
      check_pred("prediction", en ? m_bht[pi] : strong_not_taken, prediction);
      check_addr("predicted_target", en ? m_btb[pi] : '0, predicted_target);
      if (!en)
        check_inst("pc_inst", '0, pc_inst);
      else if (m_loaded[mi])           // Unloaded words hold no known value
        check_inst("pc_inst", m_mem[mi], pc_inst);
    end
  end

  ////////////////////
  // Stimulus helpers
  ////////////////////
  // Next falling edge, strobes drop unless the caller raises them again
  task automatic step();
    @(negedge clk);
    load_en   <= 1'b0;
    wen_bht   <= 1'b0;
    wen_btb   <= 1'b0;
    update_pc <= 1'b0;
  endtask

  task automatic wait_grant(input int max_cycles);
    int n;
    n = 0;
    while (dut_i.fetch_grant !== 1'b1) begin
      if (n >= max_cycles)
        report_failure("Fetch never got the memory port back after a load");
      step();
      n++;
    end
  endtask

  task automatic wait_pc(input addr_t target, input int max_cycles);
    int n;
    n = 0;
    while (pc_curr !== target) begin
      if (n >= max_cycles)
        report_failure($sformatf("PC never reached %h", target));
      step();
      n++;
    end
  endtask

  task automatic load_word(input addr_t a, input inst_t w);
    step();
    load_en   <= 1'b1;
    load_addr <= a;
    load_data <= w;
  endtask

  // Ends on the falling edge after the PC took the target
  task automatic redirect(input addr_t t);
    step();
    update_pc     <= 1'b1;
    actual_target <= t;
    step();
  endtask

  // Decode reports the counter state it fetched with
  task automatic train(input pred_idx_t idx, input logic taken);
    step();
    wen_bht       <= 1'b1;
    id_pc_idx     <= idx;
    id_prediction <= m_bht[idx];
    actual_taken  <= taken;
  endtask

  ////////////////////
  // Test sequence
  ////////////////////
  initial begin : stimulus
    addr_t p;
    addr_t a;
    addr_t tgt;
    inst_t w;
    inst_t w2;
    rst           = 1'b1;
    stall         = 1'b0;
    actual_target = '0;
    actual_taken  = 1'b0;
    wen_btb       = 1'b0;
    wen_bht       = 1'b0;
    update_pc     = 1'b0;
    id_pc_idx     = '0;
    id_prediction = strong_not_taken;
    load_en       = 1'b0;
    load_addr     = '0;
    load_data     = '0;
    repeat (5) @(posedge clk);
    step();
    check_addr("pc_curr", `PC_RESET, pc_curr);
    rst <= 1'b0;

    // Whole program, back to back, junk in the upper address bits
    for (int i = 0; i < `IMEM_DEPTH; i++)
      load_word(addr_t'({random_bits(10), i[4:0], 1'b0}), inst_t'(random_bits(16)));
    step();
    wait_grant(4);
    repeat (40) begin
      p = pc_curr;
      step();
      check_addr("pc_curr", p + addr_t'(2), pc_curr);
    end

    // Stall holds the PC and blanks the fetch outputs
    step();
    stall <= 1'b1;
    p = pc_curr;
    repeat (6) begin
      step();
      check_addr("pc_curr", p, pc_curr);
      check_inst("pc_inst", '0, pc_inst);
    end
    stall <= 1'b0;

    // Single load freezes one cycle, new word seen on a later fetch
    step();
    p = pc_curr;
    a = p + addr_t'(8);
    w = inst_t'(random_bits(16));
    load_en   <= 1'b1;
    load_addr <= a;
    load_data <= w;
    step();
    step();
    check_addr("pc_curr", p + addr_t'(2), pc_curr);
    wait_pc(a, 10);
    check_inst("pc_inst", w, pc_inst);

    // Two loads back to back
    a  = pc_curr + addr_t'(12);
    w  = inst_t'(random_bits(16));
    w2 = inst_t'(random_bits(16));
    load_word(a, w);
    load_word(a + addr_t'(2), w2);
    step();
    wait_grant(4);
    wait_pc(a, 12);
    check_inst("pc_inst", w, pc_inst);
    wait_pc(a + addr_t'(2), 4);
    check_inst("pc_inst", w2, pc_inst);

    repeat (3) begin
      tgt = random_even_addr();
      redirect(tgt);
      check_addr("pc_curr", tgt, pc_curr);
    end

    // Two taken updates at index 6 plus a target write
    tgt = random_even_addr();
    train(4'h6, 1'b1);
    wen_btb       <= 1'b1;
    actual_target <= tgt;
    train(4'h6, 1'b1);
    a = addr_t'({random_bits(12), 4'h6});
    redirect(a);
    check_pred("prediction", weak_taken, prediction);
    check_addr("predicted_target", tgt, predicted_target);
    step();
    check_addr("pc_curr", tgt, pc_curr);
    // Redirect at the predicted PC wins over the prediction
    redirect(a);
    p = tgt ^ 16'h0100;
    update_pc     <= 1'b1;
    actual_target <= p;
    step();
    check_addr("pc_curr", p, pc_curr);

    // Stall at a trained PC, taken prediction and target both blanked
    redirect(a);
    stall <= 1'b1;
    repeat (3) begin
      step();
      check_addr("pc_curr", a, pc_curr);
      check_pred("prediction", strong_not_taken, prediction);
      check_addr("predicted_target", '0, predicted_target);
    end
    stall <= 1'b0;
    step();
    check_addr("pc_curr", tgt, pc_curr);   // Jump taken once released

    // Saturation at both ends, index A
    a = addr_t'({random_bits(12), 4'hA});
    repeat (5) train(4'hA, 1'b1);
    redirect(a);
    check_pred("prediction", strong_taken, prediction);
    repeat (5) train(4'hA, 1'b0);
    redirect(a);
    check_pred("prediction", strong_not_taken, prediction);

    repeat (20) step();
    if (error_count == 0) begin
      $display("Simulation passed");
      $finish;
    end else begin
      $display("Simulation failed");
      $fatal(1, "errors were found");
    end
  end

endmodule

//--- sources.f
+incdir+logic
logic/fetch_types_pkg.sv
logic/predict_pkg.sv
logic/branch_predictor.sv
logic/fetch_stage.sv
logic/imem_arbiter.sv
logic/instr_mem.sv
logic/fetch_top.sv
test/fetch_tb.sv

//--- Bender.yml
package:
  name: fetch

sources:
  - include_dirs:
      - logic
    files:
      - logic/fetch_types_pkg.sv
      - logic/predict_pkg.sv
      - logic/branch_predictor.sv
      - logic/fetch_stage.sv
      - logic/imem_arbiter.sv
      - logic/instr_mem.sv
      - logic/fetch_top.sv
      - target: test
        include_dirs:
          - logic
        files:
          - test/fetch_tb.sv
